//--- riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  // major opcodes the buffer understands
  typedef enum logic [6:0] {
    op_imm = 7'd19,
    auipc  = 7'd23,
    op     = 7'd51,
    lui    = 7'd55
  } opcode_e;

  typedef enum logic [4:0] {
    alu_add  = 5'd0,
    alu_sub  = 5'd1,
    alu_and  = 5'd2,
    alu_or   = 5'd3,
    alu_xor  = 5'd4,
    alu_sll  = 5'd5,
    alu_srl  = 5'd6,
    alu_sra  = 5'd7,
    alu_slt  = 5'd8,
    alu_sltu = 5'd9
  } alu_op_e;

  // R-type layout, the I-type immediate overlays funct7 and rs2
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } instr_fields_t;

endpackage

`default_nettype wire

//--- rob_pkg.sv
`default_nettype none

package rob_pkg;

  import riscv_pkg::*;

  typedef logic [3:0] rob_tag_t;
  // one wider than the tag so a full buffer is representable
  typedef logic [4:0] rob_count_t;

  typedef enum logic [1:0] {
    waiting = 2'd0,
    issued  = 2'd1,
    done    = 2'd2
  } entry_state_e;

  typedef struct packed {
    logic         busy;
    entry_state_e state;
    word_t        instr;
    reg_idx_t     dest;
    word_t        value;
    word_t        pc;
  } rob_entry_t;

  typedef struct packed {
    logic     pending;
    rob_tag_t tag;
    word_t    value;
  } operand_t;

  typedef struct packed {
    logic     valid;
    alu_op_e  alu_op;
    operand_t j;
    operand_t k;
    rob_tag_t dest;
  } rs_packet_t;

  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    word_t    value;
  } cdb_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t dest;
    word_t    value;
    rob_tag_t tag;
  } commit_t;

  typedef struct packed {
    logic     pending;
    rob_tag_t tag;
    word_t    value;
  } reg_status_t;

  // complete set means the entry finished at dispatch
  typedef struct packed {
    logic     valid;
    rob_tag_t tag;
    logic     complete;
    word_t    value;
  } dispatch_mark_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    rob_tag_t tag;
  } rename_t;

endpackage

`default_nettype wire

//--- alu_decode.sv
`default_nettype none

module alu_decode (
  input  wire riscv_pkg::word_t instr,
  output riscv_pkg::alu_op_e    alu_op,
  output riscv_pkg::word_t      alu_imm,
  output logic                  uses_imm
);

  import riscv_pkg::*;

  instr_fields_t f;
  logic          alt;
  logic          is_shift;

  assign f        = instr_fields_t'(instr);
  assign uses_imm = f.opcode == op_imm;

  // instruction bit 30 selects sub and sra
  assign alt      = f.funct7[5];
  assign is_shift = (f.funct3 == 3'b001) || (f.funct3 == 3'b101);

  always_comb begin
    case (f.funct3)
      // addi has no sub form, bit 30 is part of its immediate
      3'b000:  alu_op = (alt && f.opcode == op) ? alu_sub : alu_add;
      3'b001:  alu_op = alu_sll;
      3'b010:  alu_op = alu_slt;
      3'b011:  alu_op = alu_sltu;
      3'b100:  alu_op = alu_xor;
      3'b101:  alu_op = alt ? alu_sra : alu_srl;
      3'b110:  alu_op = alu_or;
      default: alu_op = alu_and;
    endcase
  end

  // shifts carry only shamt
  assign alu_imm = is_shift ? {27'd0, f.rs2} : {{20{instr[31]}}, instr[31:20]};

endmodule

`default_nettype wire

//--- rename_regfile.sv
`default_nettype none

module rename_regfile (
  input  wire                      clk,
  input  wire                      rst,
  input  wire riscv_pkg::reg_idx_t rd_a_idx,
  output rob_pkg::reg_status_t     rd_a,
  input  wire riscv_pkg::reg_idx_t rd_b_idx,
  output rob_pkg::reg_status_t     rd_b,
  input  wire rob_pkg::rename_t    rename,
  input  wire rob_pkg::commit_t    commit
);

  import rob_pkg::*;

  // architectural value plus the tag of the youngest writer
  reg_status_t regs [32];

  assign rd_a = regs[rd_a_idx];
  assign rd_b = regs[rd_b_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (commit.valid && commit.dest != '0) begin
        regs[commit.dest].value <= commit.value;
        // a younger writer keeps the register pending
        if (regs[commit.dest].tag == commit.tag) begin
          regs[commit.dest].pending <= 1'b0;
        end
      end
      // later assignment, so a same-cycle rename wins over commit
      if (rename.valid && rename.rd != '0) begin
        regs[rename.rd].pending <= 1'b1;
        regs[rename.rd].tag     <= rename.tag;
      end
    end
  end

  a_x0_never_pending: assert property (@(posedge clk) disable iff (rst)
    !regs[0].pending)
    else $error("x0 marked pending");

endmodule

`default_nettype wire

//--- rob_entries.sv
`default_nettype none

module rob_entries #(
  parameter int DEPTH = 16
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          in_valid,
  input  wire riscv_pkg::word_t        in_instr,
  input  wire riscv_pkg::word_t        in_pc,
  output logic                         in_ready,
  input  wire rob_pkg::cdb_t           cdb,
  input  wire rob_pkg::dispatch_mark_t dispatch_mark,
  output rob_pkg::rob_entry_t          entries [DEPTH],
  output rob_pkg::rob_tag_t            head,
  output rob_pkg::rob_tag_t            tail,
  output rob_pkg::commit_t             commit
);

  import rob_pkg::*;

  rob_count_t count;
  logic       enq;
  logic       retire;

  function automatic rob_tag_t next_ptr(rob_tag_t p);
    return (p == rob_tag_t'(DEPTH - 1)) ? rob_tag_t'(0) : rob_tag_t'(p + 1'b1);
  endfunction

  assign in_ready = count < rob_count_t'(DEPTH);
  assign enq      = in_valid && in_ready;
  // head retires once its result is in
  assign retire   = (count != '0) && (entries[head].state == done);

  always_ff @(posedge clk) begin
    if (rst) begin
      head         <= '0;
      tail         <= '0;
      count        <= '0;
      commit.valid <= 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
        entries[i].busy  <= 1'b0;
        entries[i].state <= waiting;
      end
    end else begin
      if (cdb.valid) begin
        entries[cdb.tag].state <= done;
        entries[cdb.tag].value <= cdb.value;
      end

      // bus and dispatch never name the same entry
      if (dispatch_mark.valid) begin
        entries[dispatch_mark.tag].state <= dispatch_mark.complete ? done : issued;
        if (dispatch_mark.complete) begin
          entries[dispatch_mark.tag].value <= dispatch_mark.value;
        end
      end

      if (enq) begin
        entries[tail].busy  <= 1'b1;
        entries[tail].state <= waiting;
        entries[tail].instr <= in_instr;
        entries[tail].dest  <= in_instr[11:7];
        entries[tail].value <= '0;
        entries[tail].pc    <= in_pc;
        tail                <= next_ptr(tail);
      end

      // state stays done after retire so stale tags still forward
      commit.valid <= retire;
      if (retire) begin
        entries[head].busy <= 1'b0;
        commit.dest        <= entries[head].dest;
        commit.value       <= entries[head].value;
        commit.tag         <= head;
        head               <= next_ptr(head);
      end

      count <= count + rob_count_t'(enq) - rob_count_t'(retire);
    end
  end

  a_no_enq_full: assert property (@(posedge clk) disable iff (rst)
    enq |-> !entries[tail].busy)
    else $error("enqueue over a live entry of a full buffer");

  a_cdb_issued: assert property (@(posedge clk) disable iff (rst)
    cdb.valid |-> entries[cdb.tag].busy && entries[cdb.tag].state == issued)
    else $error("bus write-back to an entry that is not issued");

endmodule

`default_nettype wire

//--- dispatch_select.sv
`default_nettype none

module dispatch_select #(
  parameter int DEPTH = 16
) (
  input  wire                        clk,
  input  wire                        rst,
  input  wire rob_pkg::rob_entry_t   entries [DEPTH],
  input  wire rob_pkg::rob_tag_t     head,
  input  wire rob_pkg::rob_tag_t     tail,
  input  wire                        rs_ready,
  output riscv_pkg::word_t           sel_instr,
  output riscv_pkg::reg_idx_t        rd_a_idx,
  input  wire rob_pkg::reg_status_t  rd_a,
  output riscv_pkg::reg_idx_t        rd_b_idx,
  input  wire rob_pkg::reg_status_t  rd_b,
  input  wire riscv_pkg::alu_op_e    alu_op,
  input  wire riscv_pkg::word_t      alu_imm,
  input  wire                        uses_imm,
  output rob_pkg::dispatch_mark_t    dispatch_mark,
  output rob_pkg::rename_t           rename,
  output rob_pkg::rs_packet_t        rs_out
);

  import riscv_pkg::*;
  import rob_pkg::*;

  logic          found;
  rob_tag_t      sel_tag;
  instr_fields_t f;
  logic          is_upper;
  logic          do_upper;
  logic          do_alu;
  word_t         upper_val;
  operand_t      opnd_j;
  operand_t      opnd_k;

  // register value, value of a finished entry, or wait on the tag
  function automatic operand_t resolve(reg_status_t s);
    operand_t o;
    o.pending = 1'b0;
    o.tag     = s.tag;
    o.value   = s.value;
    if (s.pending) begin
      if (entries[s.tag].state == done) begin
        o.value = entries[s.tag].value;
      end else begin
        o.pending = 1'b1;
      end
    end
    return o;
  endfunction

  // oldest waiting entry, walking from head toward tail
  always_comb begin
    rob_tag_t idx;
    logic     stop;
    found   = 1'b0;
    sel_tag = head;
    stop    = 1'b0;
    for (int k = 0; k < DEPTH; k++) begin
      idx = rob_tag_t'((int'(head) + k) % DEPTH);
      if (k != 0 && idx == tail) begin
        stop = 1'b1;
      end
      if (!stop && !found && entries[idx].busy && entries[idx].state == waiting) begin
        found   = 1'b1;
        sel_tag = idx;
      end
    end
  end

  assign sel_instr = entries[sel_tag].instr;
  assign f         = instr_fields_t'(sel_instr);
  assign rd_a_idx  = f.rs1;
  assign rd_b_idx  = f.rs2;

  assign is_upper  = (f.opcode == lui) || (f.opcode == auipc);
  // upper immediates finish here, ALU work waits for the station
  assign do_upper  = found && is_upper;
  assign do_alu    = found && !is_upper && rs_ready;
  assign upper_val = {sel_instr[31:12], 12'd0} +
                     ((f.opcode == auipc) ? entries[sel_tag].pc : 32'd0);

  assign opnd_j = resolve(rd_a);
  assign opnd_k = uses_imm ? operand_t'{1'b0, rob_tag_t'(0), alu_imm} : resolve(rd_b);

  always_comb begin
    dispatch_mark.valid    = do_upper || do_alu;
    dispatch_mark.tag      = sel_tag;
    dispatch_mark.complete = do_upper;
    dispatch_mark.value    = upper_val;
    rename.valid           = (do_upper || do_alu) && (f.rd != '0);
    rename.rd              = f.rd;
    rename.tag             = sel_tag;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rs_out.valid <= 1'b0;
    end else begin
      rs_out.valid <= do_alu;
      if (do_alu) begin
        rs_out.alu_op <= alu_op;
        rs_out.j      <= opnd_j;
        rs_out.k      <= opnd_k;
        rs_out.dest   <= sel_tag;
      end
    end
  end

  a_rs_ready_held: assert property (@(posedge clk) disable iff (rst)
    !rs_ready |=> !rs_out.valid)
    else $error("packet sent while the reservation station was busy");

endmodule

`default_nettype wire

//--- rob_top.sv
`default_nettype none

module rob_top #(
  parameter int DEPTH = 16
) (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    in_valid,
  input  wire riscv_pkg::word_t  in_instr,
  input  wire riscv_pkg::word_t  in_pc,
  output logic                   in_ready,
  input  wire                    rs_ready,
  output rob_pkg::rs_packet_t    rs_out,
  input  wire rob_pkg::cdb_t     cdb,
  output rob_pkg::commit_t       commit
);

  import riscv_pkg::*;
  import rob_pkg::*;

  rob_entry_t     entries [DEPTH];
  rob_tag_t       head;
  rob_tag_t       tail;
  dispatch_mark_t dispatch_mark;
  rename_t        rename;
  word_t          sel_instr;
  reg_idx_t       rd_a_idx;
  reg_idx_t       rd_b_idx;
  reg_status_t    rd_a;
  reg_status_t    rd_b;
  alu_op_e        alu_op;
  word_t          alu_imm;
  logic           uses_imm;

  rob_entries #(.DEPTH(DEPTH)) u_entries (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_instr      (in_instr),
    .in_pc         (in_pc),
    .in_ready      (in_ready),
    .cdb           (cdb),
    .dispatch_mark (dispatch_mark),
    .entries       (entries),
    .head          (head),
    .tail          (tail),
    .commit        (commit)
  );

  dispatch_select #(.DEPTH(DEPTH)) u_dispatch (
    .clk           (clk),
    .rst           (rst),
    .entries       (entries),
    .head          (head),
    .tail          (tail),
    .rs_ready      (rs_ready),
    .sel_instr     (sel_instr),
    .rd_a_idx      (rd_a_idx),
    .rd_a          (rd_a),
    .rd_b_idx      (rd_b_idx),
    .rd_b          (rd_b),
    .alu_op        (alu_op),
    .alu_imm       (alu_imm),
    .uses_imm      (uses_imm),
    .dispatch_mark (dispatch_mark),
    .rename        (rename),
    .rs_out        (rs_out)
  );

  // decodes whichever entry the scan picked this cycle
  alu_decode u_decode (
    .instr    (sel_instr),
    .alu_op   (alu_op),
    .alu_imm  (alu_imm),
    .uses_imm (uses_imm)
  );

  rename_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rd_a_idx (rd_a_idx),
    .rd_a     (rd_a),
    .rd_b_idx (rd_b_idx),
    .rd_b     (rd_b),
    .rename   (rename),
    .commit   (commit)
  );

endmodule

`default_nettype wire

//--- tb_rob.sv
`default_nettype none

module tb_rob;

  import riscv_pkg::*;
  import rob_pkg::*;

  localparam int DEPTH = 16;
  // the tests take about 300 cycles after reset and the limit leaves wide margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic        clk;
  logic        rst;
  logic        in_valid;
  word_t       in_instr;
  word_t       in_pc;
  logic        in_ready;
  logic        rs_ready;
  rs_packet_t  rs_out;
  cdb_t        cdb;
  commit_t     commit;

  int          errors;
  int          checks;
  int          cycles;
  logic [31:0] rng_state;
  rob_tag_t    next_tag;
  word_t       reg_model [32];
  word_t       result_for [DEPTH];
  commit_t     exp_commits [$];
  commit_t     got_commits [$];
  rs_packet_t  got_pkts [$];

  rob_top #(.DEPTH(DEPTH)) uut (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_instr (in_instr),
    .in_pc    (in_pc),
    .in_ready (in_ready),
    .rs_ready (rs_ready),
    .rs_out   (rs_out),
    .cdb      (cdb),
    .commit   (commit)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  // registered outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!rst && commit.valid) begin
      got_commits.push_back(commit);
    end
    if (!rst && rs_out.valid) begin
      got_pkts.push_back(rs_out);
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // I-type fits too with imm[11:5] and imm[4:0] in the upper fields
  function automatic word_t rtype_word(logic [6:0] funct7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] funct3, logic [4:0] rd, logic [6:0] opc);
    return {funct7, rs2, rs1, funct3, rd, opc};
  endfunction

  function automatic word_t sign_extend_imm(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  task automatic expect_eq(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // tag only matters while the operand waits
  task automatic check_operand(string name, operand_t exp, operand_t act);
    expect_eq({name, " pending"}, 32'(exp.pending), 32'(act.pending));
    if (exp.pending) begin
      expect_eq({name, " tag"}, 32'(exp.tag), 32'(act.tag));
    end else begin
      expect_eq({name, " value"}, exp.value, act.value);
    end
  endtask

  task automatic push_instr(word_t instr, word_t pc, word_t value, output rob_tag_t tag);
    commit_t c;
    @(negedge clk);
    while (!in_ready) begin
      @(negedge clk);
    end
    in_valid = 1'b1;
    in_instr = instr;
    in_pc    = pc;
    @(negedge clk);
    in_valid = 1'b0;
    tag      = next_tag;
    c.valid  = 1'b1;
    c.dest   = instr[11:7];
    c.value  = value;
    c.tag    = next_tag;
    exp_commits.push_back(c);
    result_for[next_tag] = value;
    next_tag = rob_tag_t'((int'(next_tag) + 1) % DEPTH);
  endtask

  task automatic wait_packet(output rs_packet_t p);
    while (got_pkts.size() == 0) begin
      @(posedge clk);
    end
    p = got_pkts.pop_front();
  endtask

  task automatic send_result(rob_tag_t tag);
    @(negedge clk);
    cdb.valid = 1'b1;
    cdb.tag   = tag;
    cdb.value = result_for[tag];
    @(negedge clk);
    cdb.valid = 1'b0;
  endtask

  // compares in-order retires and updates the architectural model
  task automatic drain_commits(string name);
    commit_t e;
    commit_t a;
    while (got_commits.size() < exp_commits.size()) begin
      @(posedge clk);
    end
    while (exp_commits.size() > 0) begin
      e = exp_commits.pop_front();
      a = got_commits.pop_front();
      expect_eq({name, " commit dest"}, 32'(e.dest), 32'(a.dest));
      expect_eq({name, " commit value"}, e.value, a.value);
      expect_eq({name, " commit tag"}, 32'(e.tag), 32'(a.tag));
      if (e.dest != 5'd0) begin
        reg_model[e.dest] = e.value;
      end
    end
  endtask

  // one ALU instruction with committed sources from enqueue to retire
  task automatic run_alu(string name, word_t instr, alu_op_e exp_op, word_t exp_imm);
    rob_tag_t   tag;
    rs_packet_t p;
    operand_t   ej;
    operand_t   ek;
    ej.pending = 1'b0;
    ej.tag     = '0;
    ej.value   = reg_model[instr[19:15]];
    ek.pending = 1'b0;
    ek.tag     = '0;
    if (instr[6:0] == op_imm) begin
      ek.value = exp_imm;
    end else begin
      ek.value = reg_model[instr[24:20]];
    end
    push_instr(instr, 32'h0000_4000, next_random(), tag);
    wait_packet(p);
    expect_eq({name, " alu_op"}, 32'(exp_op), 32'(p.alu_op));
    expect_eq({name, " dest tag"}, 32'(tag), 32'(p.dest));
    check_operand({name, " j"}, ej, p.j);
    check_operand({name, " k"}, ek, p.k);
    send_result(tag);
    drain_commits(name);
  endtask

  task automatic reset_outputs();
    @(negedge clk);
    expect_eq("reset in_ready", 32'd1, 32'(in_ready));
    expect_eq("reset rs_out.valid", 32'd0, 32'(rs_out.valid));
    expect_eq("reset commit.valid", 32'd0, 32'(commit.valid));
  endtask

  // fills x1..x6 for the later tests
  task automatic upper_imm_commits();
    logic [19:0] imm;
    word_t       pc;
    rob_tag_t    tag;
    for (int i = 0; i < 6; i++) begin
      imm = 20'(next_random());
      pc  = 32'h0000_1000 + 32'(4 * i);
      if (i % 2 == 0) begin
        push_instr({imm, 5'(i + 1), lui}, pc, {imm, 12'd0}, tag);
      end else begin
        push_instr({imm, 5'(i + 1), auipc}, pc, pc + {imm, 12'd0}, tag);
      end
    end
    drain_commits("upper_imm");
    expect_eq("upper_imm no packet", 32'd0, 32'(got_pkts.size()));
  endtask

  task automatic alu_op_decode();
    logic [11:0] imm;
    run_alu("add", rtype_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd10, op), alu_add, 32'd0);
    run_alu("sub", rtype_word(7'h20, 5'd3, 5'd2, 3'd0, 5'd11, op), alu_sub, 32'd0);
    run_alu("sll", rtype_word(7'h00, 5'd4, 5'd3, 3'd1, 5'd12, op), alu_sll, 32'd0);
    run_alu("slt", rtype_word(7'h00, 5'd5, 5'd4, 3'd2, 5'd13, op), alu_slt, 32'd0);
    run_alu("sltu", rtype_word(7'h00, 5'd6, 5'd5, 3'd3, 5'd14, op), alu_sltu, 32'd0);
    run_alu("xor", rtype_word(7'h00, 5'd1, 5'd6, 3'd4, 5'd15, op), alu_xor, 32'd0);
    run_alu("srl", rtype_word(7'h00, 5'd2, 5'd1, 3'd5, 5'd16, op), alu_srl, 32'd0);
    run_alu("sra", rtype_word(7'h20, 5'd3, 5'd2, 3'd5, 5'd17, op), alu_sra, 32'd0);
    run_alu("or", rtype_word(7'h00, 5'd4, 5'd3, 3'd6, 5'd10, op), alu_or, 32'd0);
    run_alu("and", rtype_word(7'h00, 5'd5, 5'd4, 3'd7, 5'd11, op), alu_and, 32'd0);
    // bit 30 of the addi immediate is set and must not turn it into sub
    imm     = 12'(next_random());
    imm[10] = 1'b1;
    run_alu("addi", rtype_word(imm[11:5], imm[4:0], 5'd1, 3'd0, 5'd12, op_imm), alu_add,
            sign_extend_imm(imm));
    imm = 12'(next_random());
    run_alu("slti", rtype_word(imm[11:5], imm[4:0], 5'd2, 3'd2, 5'd13, op_imm), alu_slt,
            sign_extend_imm(imm));
    imm = 12'(next_random());
    run_alu("sltiu", rtype_word(imm[11:5], imm[4:0], 5'd3, 3'd3, 5'd14, op_imm), alu_sltu,
            sign_extend_imm(imm));
    imm = 12'(next_random());
    run_alu("xori", rtype_word(imm[11:5], imm[4:0], 5'd4, 3'd4, 5'd15, op_imm), alu_xor,
            sign_extend_imm(imm));
    imm = 12'(next_random());
    run_alu("ori", rtype_word(imm[11:5], imm[4:0], 5'd5, 3'd6, 5'd16, op_imm), alu_or,
            sign_extend_imm(imm));
    imm = 12'(next_random());
    run_alu("andi", rtype_word(imm[11:5], imm[4:0], 5'd6, 3'd7, 5'd17, op_imm), alu_and,
            sign_extend_imm(imm));
    imm = 12'(next_random());
    run_alu("slli", rtype_word(7'h00, imm[4:0], 5'd1, 3'd1, 5'd10, op_imm), alu_sll,
            32'(imm[4:0]));
    run_alu("srli", rtype_word(7'h00, imm[9:5], 5'd2, 3'd5, 5'd11, op_imm), alu_srl,
            32'(imm[9:5]));
    run_alu("srai", rtype_word(7'h20, imm[4:0], 5'd3, 3'd5, 5'd12, op_imm), alu_sra,
            32'(imm[4:0]));
  endtask

  task automatic dependency_forwarding();
    rob_tag_t   ta;
    rob_tag_t   tb;
    rob_tag_t   tc;
    rs_packet_t p;
    operand_t   e;
    push_instr(rtype_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd20, op), 32'h0000_2000,
               next_random(), ta);
    wait_packet(p);
    // reader of x20 while its writer is still issued
    push_instr(rtype_word(7'h00, 5'd3, 5'd20, 3'd0, 5'd21, op), 32'h0000_2004,
               next_random(), tb);
    wait_packet(p);
    e.pending = 1'b1;
    e.tag     = ta;
    e.value   = '0;
    check_operand("dependency pending j", e, p.j);
    e.pending = 1'b0;
    e.value   = reg_model[3];
    check_operand("dependency k", e, p.k);
    // younger result first
    send_result(tb);
    send_result(ta);
    push_instr(rtype_word(7'h00, 5'd21, 5'd20, 3'd0, 5'd22, op), 32'h0000_2008,
               next_random(), tc);
    wait_packet(p);
    e.value = result_for[ta];
    check_operand("dependency forwarded j", e, p.j);
    e.value = result_for[tb];
    check_operand("dependency forwarded k", e, p.k);
    send_result(tc);
    drain_commits("dependency");
  endtask

  task automatic full_buffer_stall();
    rob_tag_t   tags [DEPTH];
    rs_packet_t p;
    @(negedge clk);
    rs_ready = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      push_instr(rtype_word(7'h00, 5'(i), 5'd1, 3'd0, 5'd23, op_imm),
                 32'h0000_3000 + 32'(4 * i), next_random(), tags[i]);
    end
    expect_eq("backpressure full in_ready", 32'd0, 32'(in_ready));
    repeat (4) @(negedge clk);
    expect_eq("backpressure no packet", 32'd0, 32'(got_pkts.size()));
    rs_ready = 1'b1;
    for (int i = 0; i < DEPTH; i++) begin
      wait_packet(p);
      expect_eq("backpressure dest tag", 32'(tags[i]), 32'(p.dest));
      expect_eq("backpressure k", 32'(i), p.k.value);
      send_result(tags[i]);
      if (i == 0) begin
        // one more edge after the bus write-back retires the head
        @(negedge clk);
        expect_eq("backpressure in_ready after retire", 32'd1, 32'(in_ready));
      end
    end
    drain_commits("backpressure");
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    in_instr  = '0;
    in_pc     = '0;
    rs_ready  = 1'b1;
    cdb       = '0;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    rng_state = 32'd61;
    next_tag  = '0;
    for (int i = 0; i < 32; i++) begin
      reg_model[i] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    reset_outputs();
    upper_imm_commits();
    alu_op_decode();
    dependency_forwarding();
    full_buffer_stall();
    expect_eq("no stray commits", 32'd0, 32'(got_commits.size()));
    expect_eq("no stray packets", 32'd0, 32'(got_pkts.size()));

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
riscv_pkg.sv
rob_pkg.sv
alu_decode.sv
rename_regfile.sv
rob_entries.sv
dispatch_select.sv
rob_top.sv
tb_rob.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_rob
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
